//--- hw/fixed_point_pkg.sv
package fixed_point_pkg;

	////////////////////
	// 4.23 number format
	////////////////////

	// sign plus 3 integer bits, 23 fraction bits
	typedef logic signed [26:0] fixed_t;

	// 1.0
	localparam fixed_t FIX_ONE = 27'sh0800000;
	// bailout bound on |z| squared, 4.0
	localparam fixed_t ESCAPE_LIMIT = 27'sh2000000;

	// left screen edge, -2.0
	localparam fixed_t ORIGIN_RE = -27'sh1000000;
	// top screen edge, 1.0
	localparam fixed_t ORIGIN_IM = 27'sh0800000;

	// one pan command moves the view by 1/256
	localparam fixed_t PAN_STEP = 27'sh0008000;

	////////////////////
	// scaled multiply
	////////////////////

	// full 54-bit product, keep sign and bits 48..23
	function automatic fixed_t fix_mul(fixed_t a, fixed_t b);
		logic signed [53:0] prod;
		prod = a * b;
		return {prod[53], prod[48:23]};
	endfunction

endpackage

//--- hw/render_pkg.sv
package render_pkg;

	// pixel coordinate, up to 1023
	typedef logic [9:0] coord_t;
	// frame address, y * SCREEN_W + x
	typedef logic [18:0] pixel_addr_t;
	// rgb332
	typedef logic [7:0] color_t;
	typedef logic [15:0] iter_t;

	////////////////////
	// state encodings
	////////////////////

	typedef enum logic [2:0] {
		LANE_START,
		LANE_SOLVE,
		LANE_SHADE,
		LANE_WRITE,
		LANE_DONE
	} lane_state_e;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_SETUP,
		ARB_ACCESS
	} arb_state_e;

	////////////////////
	// palette
	////////////////////

	// entry 0 is the inside color, entry n for count >= max >> n, entry 9 below all
	localparam color_t PALETTE [0:9] = '{
		8'b000_000_00,
		8'b011_001_00,
		8'b011_001_00,
		8'b101_010_01,
		8'b011_001_01,
		8'b001_001_01,
		8'b011_010_10,
		8'b010_100_10,
		8'b010_100_10,
		8'b010_100_10
	};

	// escape count to color
	function automatic color_t palette_color(iter_t count, iter_t max_iter);
		color_t result;
		result = PALETTE[9];
		// walk thresholds upward so the largest one wins
		for (int n = 8; n >= 1; n--) begin
			if (count >= (max_iter >> n))
				result = PALETTE[n];
		end
		if (count >= max_iter)
			result = PALETTE[0];
		return result;
	endfunction

endpackage

//--- hw/pixel_port_if.sv
`timescale 1ns/100ps

// one pixel write, lane to arbiter
interface pixel_port_if;

	// raised by the lane, addr and color held until ack
	logic req;
	render_pkg::pixel_addr_t addr;
	render_pkg::color_t color;
	// single-cycle completion back to the lane
	logic ack;

	modport lane (
		output req,
		output addr,
		output color,
		input  ack
	);

	modport arbiter (
		input  req,
		input  addr,
		input  color,
		output ack
	);

endinterface

//--- hw/escape_iterator.sv
`timescale 1ns/100ps

module escape_iterator #(
	parameter int MAX_ITER = 1000
) (
	input  logic clk,
	input  logic reset,
	input  logic start_i,
	input  fixed_point_pkg::fixed_t c_re_i,
	input  fixed_point_pkg::fixed_t c_im_i,
	output render_pkg::iter_t iter_o,
	output logic done_o
);

	// bailout bound on either part of z, 2.0
	localparam fixed_point_pkg::fixed_t PART_LIMIT = fixed_point_pkg::FIX_ONE <<< 1;

	fixed_point_pkg::fixed_t z_re;
	fixed_point_pkg::fixed_t z_im;
	fixed_point_pkg::fixed_t z_re_sq;
	fixed_point_pkg::fixed_t z_im_sq;
	fixed_point_pkg::fixed_t z_cross;
	// one extra bit so 4 + 4 does not wrap
	logic signed [27:0] mag_sq;
	logic escaped;
	logic running;

	////////////////////
	// datapath
	////////////////////

	assign z_re_sq = fixed_point_pkg::fix_mul(z_re, z_re);
	assign z_im_sq = fixed_point_pkg::fix_mul(z_im, z_im);
	assign z_cross = fixed_point_pkg::fix_mul(z_re, z_im);
	assign mag_sq = z_re_sq + z_im_sq;

	// checked on the current z, before the next step
	assign escaped = (mag_sq > fixed_point_pkg::ESCAPE_LIMIT) ||
		(z_re > PART_LIMIT) || (z_re < -PART_LIMIT) ||
		(z_im > PART_LIMIT) || (z_im < -PART_LIMIT);

	////////////////////
	// one step per clock
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			done_o <= 1'b0;
			iter_o <= '0;
		end else if (start_i) begin
			// z starts at the origin
			running <= 1'b1;
			done_o <= 1'b0;
			iter_o <= '0;
			z_re <= '0;
			z_im <= '0;
		end else if (running) begin
			if (escaped || (iter_o >= MAX_ITER)) begin
				running <= 1'b0;
				done_o <= 1'b1;
			end else begin
				// z = z^2 + c
				z_re <= z_re_sq - z_im_sq + c_re_i;
				z_im <= (z_cross <<< 1) + c_im_i;
				iter_o <= iter_o + 1'b1;
			end
		end
	end

endmodule

//--- hw/scan_lane.sv
`timescale 1ns/100ps

module scan_lane #(
	parameter int LANE_ID = 0,
	parameter int NUM_LANES = 2,
	parameter int SCREEN_W = 640,
	parameter int SCREEN_H = 480,
	parameter int MAX_ITER = 1000
) (
	input  logic clk,
	input  logic reset,
	input  logic restart_i,
	input  fixed_point_pkg::fixed_t step_i,
	input  fixed_point_pkg::fixed_t pan_re_i,
	input  fixed_point_pkg::fixed_t pan_im_i,
	pixel_port_if.lane pix,
	output logic done_o
);

	render_pkg::lane_state_e state;
	render_pkg::coord_t x;
	render_pkg::coord_t y;
	fixed_point_pkg::fixed_t c_re;
	fixed_point_pkg::fixed_t c_im;
	// c distance between two pixels of this lane
	fixed_point_pkg::fixed_t stride;
	fixed_point_pkg::fixed_t lane_off;
	// c_re of this lane's first column
	fixed_point_pkg::fixed_t row_re;
	logic iter_start;
	logic iter_done;
	render_pkg::iter_t iter_count;

	assign stride = fixed_point_pkg::fixed_t'(NUM_LANES * step_i);
	assign lane_off = fixed_point_pkg::fixed_t'(LANE_ID * step_i);
	assign row_re = fixed_point_pkg::ORIGIN_RE + pan_re_i + lane_off;

	escape_iterator #(
		.MAX_ITER(MAX_ITER)
	) escape_iterator_i (
		.clk(clk),
		.reset(reset),
		.start_i(iter_start),
		.c_re_i(c_re),
		.c_im_i(c_im),
		.iter_o(iter_count),
		.done_o(iter_done)
	);

	assign pix.req = (state == render_pkg::LANE_WRITE);
	assign done_o = (state == render_pkg::LANE_DONE);

	////////////////////
	// pixel walker
	////////////////////

	always_ff @(posedge clk) begin
		if (reset || restart_i) begin
			state <= render_pkg::LANE_START;
			iter_start <= 1'b0;
		end else begin
			iter_start <= 1'b0;
			case (state)
				render_pkg::LANE_START: begin
					// top-left pixel of this lane
					x <= render_pkg::coord_t'(LANE_ID);
					y <= '0;
					c_re <= row_re;
					c_im <= fixed_point_pkg::ORIGIN_IM + pan_im_i;
					iter_start <= 1'b1;
					state <= render_pkg::LANE_SOLVE;
				end
				render_pkg::LANE_SOLVE: begin
					// done is stale while the start pulse is still out
					if (iter_done && !iter_start)
						state <= render_pkg::LANE_SHADE;
				end
				render_pkg::LANE_SHADE: begin
					pix.addr <= render_pkg::pixel_addr_t'(int'(y) * SCREEN_W + int'(x));
					pix.color <= render_pkg::palette_color(iter_count,
						render_pkg::iter_t'(MAX_ITER));
					state <= render_pkg::LANE_WRITE;
				end
				render_pkg::LANE_WRITE: begin
					if (pix.ack) begin
						if (int'(x) + NUM_LANES < SCREEN_W) begin
							// next column of the lane
							x <= x + render_pkg::coord_t'(NUM_LANES);
							c_re <= c_re + stride;
							iter_start <= 1'b1;
							state <= render_pkg::LANE_SOLVE;
						end else if (int'(y) == SCREEN_H - 1) begin
							state <= render_pkg::LANE_DONE;
						end else begin
							// wrap to next row, imaginary part goes down
							x <= render_pkg::coord_t'(LANE_ID);
							y <= y + 1'b1;
							c_re <= row_re;
							c_im <= c_im - step_i;
							iter_start <= 1'b1;
							state <= render_pkg::LANE_SOLVE;
						end
					end
				end
				// parked until restart
				render_pkg::LANE_DONE: state <= render_pkg::LANE_DONE;
				default: state <= render_pkg::LANE_START;
			endcase
		end
	end

endmodule

//--- hw/view_control.sv
`timescale 1ns/100ps

module view_control #(
	parameter fixed_point_pkg::fixed_t BASE_STEP = 27'sd39322,
	parameter int ZOOM_MAX = 8
) (
	input  logic clk,
	input  logic reset,
	input  logic zoom_in_i,
	input  logic zoom_out_i,
	input  logic pan_left_i,
	input  logic pan_right_i,
	input  logic pan_up_i,
	input  logic pan_down_i,
	output logic restart_o,
	output fixed_point_pkg::fixed_t step_o,
	output fixed_point_pkg::fixed_t pan_re_o,
	output fixed_point_pkg::fixed_t pan_im_o
);

	localparam int ZW = $clog2(ZOOM_MAX + 1);

	logic [ZW-1:0] zoom_q;
	logic any_cmd;

	assign any_cmd = zoom_in_i | zoom_out_i | pan_left_i | pan_right_i |
		pan_up_i | pan_down_i;

	// each zoom level halves the pixel width
	assign step_o = BASE_STEP >>> zoom_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			zoom_q <= '0;
			pan_re_o <= '0;
			pan_im_o <= '0;
			restart_o <= 1'b0;
		end else begin
			// every command redraws, even a saturated zoom
			restart_o <= any_cmd;
			// zoom in wins, level saturates at both ends
			if (zoom_in_i) begin
				if (int'(zoom_q) < ZOOM_MAX)
					zoom_q <= zoom_q + 1'b1;
			end else if (zoom_out_i) begin
				if (zoom_q != '0)
					zoom_q <= zoom_q - 1'b1;
			end
			if (pan_right_i)
				pan_re_o <= pan_re_o + fixed_point_pkg::PAN_STEP;
			else if (pan_left_i)
				pan_re_o <= pan_re_o - fixed_point_pkg::PAN_STEP;
			// screen down is toward negative imaginary
			if (pan_down_i)
				pan_im_o <= pan_im_o - fixed_point_pkg::PAN_STEP;
			else if (pan_up_i)
				pan_im_o <= pan_im_o + fixed_point_pkg::PAN_STEP;
		end
	end

endmodule

//--- hw/fb_write_arbiter.sv
`timescale 1ns/100ps

module fb_write_arbiter #(
	parameter int NUM_LANES = 2
) (
	input  logic clk,
	input  logic reset,
	input  logic restart_i,
	pixel_port_if.arbiter lanes [NUM_LANES],
	output logic psel_o,
	output logic penable_o,
	output logic pwrite_o,
	output render_pkg::pixel_addr_t paddr_o,
	output render_pkg::color_t pwdata_o,
	input  logic pready_i,
	output logic idle_o
);

	localparam int IW = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

	render_pkg::arb_state_e state;
	logic [NUM_LANES-1:0] req_v;
	logic [NUM_LANES-1:0] req_masked;
	render_pkg::pixel_addr_t addr_v [NUM_LANES];
	render_pkg::color_t color_v [NUM_LANES];
	// last lane served, rotation starts after it
	logic [IW-1:0] grant_q;
	logic [IW-1:0] pick;
	logic pick_valid;
	logic xfer_done;
	logic start_xfer;
	// transfer in flight belongs to a frame that was restarted
	logic drop_q;

	for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
		assign req_v[g] = lanes[g].req;
		assign addr_v[g] = lanes[g].addr;
		assign color_v[g] = lanes[g].color;
		assign lanes[g].ack = xfer_done && (grant_q == IW'(g)) && !drop_q && !restart_i;
	end

	assign xfer_done = (state == render_pkg::ARB_ACCESS) && pready_i;
	assign start_xfer = pick_valid && !restart_i &&
		((state == render_pkg::ARB_IDLE) || xfer_done);

	////////////////////
	// round robin
	////////////////////

	always_comb begin
		req_masked = req_v;
		// served lane still shows req in its ack cycle
		if (state == render_pkg::ARB_ACCESS)
			req_masked[grant_q] = 1'b0;
	end

	always_comb begin
		int idx;
		pick = grant_q;
		pick_valid = 1'b0;
		for (int k = 1; k <= NUM_LANES; k++) begin
			idx = int'(grant_q) + k;
			if (idx >= NUM_LANES)
				idx = idx - NUM_LANES;
			if (!pick_valid && req_masked[idx]) begin
				pick = IW'(idx);
				pick_valid = 1'b1;
			end
		end
	end

	////////////////////
	// apb requester
	////////////////////

	assign psel_o = (state != render_pkg::ARB_IDLE);
	assign penable_o = (state == render_pkg::ARB_ACCESS);
	assign pwrite_o = psel_o;
	assign idle_o = (state == render_pkg::ARB_IDLE);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= render_pkg::ARB_IDLE;
			grant_q <= IW'(NUM_LANES - 1);
			drop_q <= 1'b0;
		end else begin
			if (xfer_done)
				drop_q <= 1'b0;
			else if (restart_i && (state != render_pkg::ARB_IDLE))
				drop_q <= 1'b1;
			// back-to-back when another lane waits
			if (start_xfer) begin
				grant_q <= pick;
				state <= render_pkg::ARB_SETUP;
			end else if (state == render_pkg::ARB_SETUP) begin
				state <= render_pkg::ARB_ACCESS;
			end else if (xfer_done) begin
				state <= render_pkg::ARB_IDLE;
			end
		end
	end

	// address and data held for the whole transfer
	always_ff @(posedge clk) begin
		if (start_xfer) begin
			paddr_o <= addr_v[pick];
			pwdata_o <= color_v[pick];
		end
	end

endmodule

//--- hw/mandel_render_top.sv
`timescale 1ns/100ps

module mandel_render_top #(
	parameter int SCREEN_W = 640,
	parameter int SCREEN_H = 480,
	parameter int MAX_ITER = 1000,
	parameter int NUM_LANES = 2,
	// 3/640 in 4.23
	parameter fixed_point_pkg::fixed_t BASE_STEP = 27'sd39322,
	parameter int ZOOM_MAX = 8
) (
	input  logic clk,
	input  logic reset,
	input  logic zoom_in_i,
	input  logic zoom_out_i,
	input  logic pan_left_i,
	input  logic pan_right_i,
	input  logic pan_up_i,
	input  logic pan_down_i,
	output logic psel_o,
	output logic penable_o,
	output logic pwrite_o,
	output render_pkg::pixel_addr_t paddr_o,
	output render_pkg::color_t pwdata_o,
	input  logic pready_i,
	output logic frame_done_o
);

	logic restart;
	fixed_point_pkg::fixed_t step;
	fixed_point_pkg::fixed_t pan_re;
	fixed_point_pkg::fixed_t pan_im;
	logic [NUM_LANES-1:0] lane_done;
	logic arb_idle;

	// one write port per lane
	pixel_port_if pix [NUM_LANES] ();

	view_control #(
		.BASE_STEP(BASE_STEP),
		.ZOOM_MAX(ZOOM_MAX)
	) view_control_i (
		.clk(clk),
		.reset(reset),
		.zoom_in_i(zoom_in_i),
		.zoom_out_i(zoom_out_i),
		.pan_left_i(pan_left_i),
		.pan_right_i(pan_right_i),
		.pan_up_i(pan_up_i),
		.pan_down_i(pan_down_i),
		.restart_o(restart),
		.step_o(step),
		.pan_re_o(pan_re),
		.pan_im_o(pan_im)
	);

	// lane k owns columns k, k + NUM_LANES, ...
	for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
		scan_lane #(
			.LANE_ID(g),
			.NUM_LANES(NUM_LANES),
			.SCREEN_W(SCREEN_W),
			.SCREEN_H(SCREEN_H),
			.MAX_ITER(MAX_ITER)
		) scan_lane_i (
			.clk(clk),
			.reset(reset),
			.restart_i(restart),
			.step_i(step),
			.pan_re_i(pan_re),
			.pan_im_i(pan_im),
			.pix(pix[g]),
			.done_o(lane_done[g])
		);
	end

	fb_write_arbiter #(
		.NUM_LANES(NUM_LANES)
	) fb_write_arbiter_i (
		.clk(clk),
		.reset(reset),
		.restart_i(restart),
		.lanes(pix),
		.psel_o(psel_o),
		.penable_o(penable_o),
		.pwrite_o(pwrite_o),
		.paddr_o(paddr_o),
		.pwdata_o(pwdata_o),
		.pready_i(pready_i),
		.idle_o(arb_idle)
	);

	// all lanes parked and no write left on the bus
	assign frame_done_o = (&lane_done) && arb_idle;

endmodule

//--- verification/mandel_render_tb.sv
`timescale 1ns/100ps

module mandel_render_tb;

	localparam int SCREEN_W = 16;
	localparam int SCREEN_H = 12;
	localparam int MAX_ITER = 64;
	localparam int NPIX = SCREEN_W * SCREEN_H;
	// 3/16 in 4.23
	localparam fixed_point_pkg::fixed_t BASE_STEP = 27'sd1572864;

	logic clk;
	logic reset;
	logic zoom_in_i;
	logic zoom_out_i;
	logic pan_left_i;
	logic pan_right_i;
	logic pan_up_i;
	logic pan_down_i;
	logic psel_o;
	logic penable_o;
	logic pwrite_o;
	logic pready_i;
	logic frame_done_o;
	render_pkg::pixel_addr_t paddr_o;
	render_pkg::color_t pwdata_o;

	// completer memory and per-address write counts
	render_pkg::color_t frame_mem [0:NPIX-1];
	render_pkg::color_t first_frame [0:NPIX-1];
	int write_count [0:NPIX-1];

	// parsed stimulus
	string op_q[$];
	string name_q[$];
	int x_q[$];
	int y_q[$];
	int c_q[$];
	int num_steps;
	logic limit_ready;

	logic [31:0] rng;
	logic prev_psel;
	logic prev_pen;
	logic prev_ready;
	render_pkg::pixel_addr_t prev_addr;
	render_pkg::color_t prev_data;

	mandel_render_top #(
		.SCREEN_W(SCREEN_W),
		.SCREEN_H(SCREEN_H),
		.MAX_ITER(MAX_ITER),
		.NUM_LANES(2),
		.BASE_STEP(BASE_STEP),
		.ZOOM_MAX(8)
	) mandel_render_top_i (
		.clk(clk),
		.reset(reset),
		.zoom_in_i(zoom_in_i),
		.zoom_out_i(zoom_out_i),
		.pan_left_i(pan_left_i),
		.pan_right_i(pan_right_i),
		.pan_up_i(pan_up_i),
		.pan_down_i(pan_down_i),
		.psel_o(psel_o),
		.penable_o(penable_o),
		.pwrite_o(pwrite_o),
		.paddr_o(paddr_o),
		.pwdata_o(pwdata_o),
		.pready_i(pready_i),
		.frame_done_o(frame_done_o)
	);

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////
	// helpers
	////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic report_mismatch(input string msg);
		$display("CHECK FAILED at %0t: %s", $time, msg);
		$display("Simulation FAILED");
		$fatal(1, "mismatch");
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "aborted");
	endtask

	task automatic check_color(input render_pkg::color_t act, input render_pkg::color_t exp,
		input string msg);
		if (act !== exp)
			report_mismatch($sformatf("%s: color %h, expected %h", msg, act, exp));
	endtask

	task automatic check_addr(input render_pkg::pixel_addr_t act,
		input render_pkg::pixel_addr_t exp, input string msg);
		if (act !== exp)
			report_mismatch($sformatf("%s: address %0d, expected %0d", msg, act, exp));
	endtask

	task automatic check_count(input integer act, input integer exp, input string msg);
		if (act !== exp)
			report_mismatch($sformatf("%s: got %0d, expected %0d", msg, act, exp));
	endtask

	////////////////////
	// apb completer and protocol monitor
	////////////////////

	always @(posedge clk) begin
		if (reset) begin
			prev_psel = 1'b0;
			prev_pen = 1'b0;
			prev_ready = 1'b0;
		end else begin
			if (penable_o && !psel_o)
				report_mismatch("penable without psel");
			if (psel_o) begin
				check_count(int'(paddr_o < NPIX), 1, "paddr below frame size");
				check_count(int'(pwrite_o), 1, "pwrite during transfer");
			end
			// setup is always followed by access
			if (prev_psel && !prev_pen && !(psel_o && penable_o))
				report_mismatch("setup not followed by access");
			// a waited access must continue
			if (prev_psel && prev_pen && !prev_ready && !(psel_o && penable_o))
				report_mismatch("transfer dropped while pready low");
			if (psel_o && penable_o) begin
				// previous cycle was the setup or a waited access of this transfer
				check_count(int'(prev_psel && (!prev_pen || !prev_ready)), 1,
					"access without setup");
				check_addr(paddr_o, prev_addr, "paddr stable");
				check_color(pwdata_o, prev_data, "pwdata stable");
				if (pready_i) begin
					frame_mem[paddr_o] = pwdata_o;
					write_count[paddr_o] = write_count[paddr_o] + 1;
				end
			end
			prev_psel = psel_o;
			prev_pen = penable_o;
			prev_ready = pready_i;
		end
		prev_addr = paddr_o;
		prev_data = pwdata_o;
		// random back-pressure, high about three times in four
		rng = lcg_next(rng);
		pready_i <= (rng[31:30] != 2'b00);
	end

	////////////////////
	// watchdog
	////////////////////

	initial begin
		wait (limit_ready === 1'b1);
		repeat (num_steps * NPIX * (MAX_ITER + 10) + 100) @(posedge clk);
		abort_run("Timeout: frame rendering did not finish in time");
	end

	////////////////////
	// stimulus
	////////////////////

	task automatic read_stimulus();
		int fd;
		int r;
		int x;
		int y;
		int c;
		string tok;
		string arg;
		string line;
		fd = $fopen("verification/mandel_stimulus.txt", "r");
		if (fd == 0)
			abort_run("Cannot open verification/mandel_stimulus.txt");
		num_steps = 0;
		while (!$feof(fd)) begin
			r = $fscanf(fd, "%s", tok);
			if (r != 1)
				break;
			if (tok.substr(0, 0) == "#") begin
				r = $fgets(line, fd);
			end else if (tok == "cmd") begin
				r = $fscanf(fd, "%s", arg);
				op_q.push_back(tok);
				name_q.push_back(arg);
				x_q.push_back(0);
				y_q.push_back(0);
				c_q.push_back(0);
				num_steps++;
			end else if (tok == "pix") begin
				r = $fscanf(fd, "%d %d %h", x, y, c);
				op_q.push_back(tok);
				name_q.push_back("");
				x_q.push_back(x);
				y_q.push_back(y);
				c_q.push_back(c);
			end else if (tok == "match_first") begin
				op_q.push_back(tok);
				name_q.push_back("");
				x_q.push_back(0);
				y_q.push_back(0);
				c_q.push_back(0);
			end else begin
				abort_run({"Unknown word in stimulus file: ", tok});
			end
		end
		$fclose(fd);
	endtask

	// one-cycle command pulse, counts cleared with it
	task automatic apply_command(input string name);
		@(posedge clk);
		case (name)
			"zoom_in": zoom_in_i <= 1'b1;
			"zoom_out": zoom_out_i <= 1'b1;
			"pan_left": pan_left_i <= 1'b1;
			"pan_right": pan_right_i <= 1'b1;
			"pan_up": pan_up_i <= 1'b1;
			"pan_down": pan_down_i <= 1'b1;
			default: abort_run({"Unknown command in stimulus file: ", name});
		endcase
		for (int a = 0; a < NPIX; a++)
			write_count[a] = 0;
		@(posedge clk);
		{zoom_in_i, zoom_out_i, pan_left_i, pan_right_i, pan_up_i, pan_down_i} <= '0;
	endtask

	task automatic run_frame(input string name, input int step_idx);
		int waited;
		if (name != "none") begin
			apply_command(name);
			// old frame_done must drop once the lanes restart
			waited = 0;
			@(negedge clk);
			while (frame_done_o && waited < 10) begin
				@(negedge clk);
				waited++;
			end
			if (frame_done_o)
				abort_run("frame_done_o stayed high after a command");
		end
		while (!frame_done_o)
			@(negedge clk);
		for (int a = 0; a < NPIX; a++)
			check_count(write_count[a], 1, $sformatf("writes to address %0d", a));
		if (step_idx == 0) begin
			for (int a = 0; a < NPIX; a++)
				first_frame[a] = frame_mem[a];
		end
	endtask

	initial begin
		int step_idx;
		render_pkg::pixel_addr_t addr;
		reset <= 1'b1;
		pready_i <= 1'b0;
		{zoom_in_i, zoom_out_i, pan_left_i, pan_right_i, pan_up_i, pan_down_i} <= '0;
		rng = 32'h2974;
		limit_ready = 1'b0;
		for (int a = 0; a < NPIX; a++) begin
			write_count[a] = 0;
			// fill follows the address, frame fits in 8 bits
			frame_mem[a] = render_pkg::color_t'(a);
		end
		read_stimulus();
		limit_ready = 1'b1;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_count(int'(psel_o), 0, "psel after reset");
		check_count(int'(penable_o), 0, "penable after reset");
		check_count(int'(frame_done_o), 0, "frame_done after reset");
		step_idx = -1;
		for (int i = 0; i < op_q.size(); i++) begin
			if (op_q[i] == "cmd") begin
				step_idx++;
				run_frame(name_q[i], step_idx);
			end else if (op_q[i] == "pix") begin
				addr = render_pkg::pixel_addr_t'(y_q[i] * SCREEN_W + x_q[i]);
				check_color(frame_mem[addr], render_pkg::color_t'(c_q[i]),
					$sformatf("step %0d pixel (%0d,%0d)", step_idx, x_q[i], y_q[i]));
			end else begin
				for (int a = 0; a < NPIX; a++)
					check_color(frame_mem[a], first_frame[a],
						$sformatf("step %0d address %0d against first frame", step_idx, a));
			end
		end
		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- mandel_render.f
hw/fixed_point_pkg.sv
hw/render_pkg.sv
hw/pixel_port_if.sv
hw/escape_iterator.sv
hw/scan_lane.sv
hw/view_control.sv
hw/fb_write_arbiter.sv
hw/mandel_render_top.sv
verification/mandel_render_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing -j 0 -Wno-fatal
TOP = mandel_render_tb
FILELIST = mandel_render.f
OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, search the output for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep "Simulation PASSED" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

//--- verification/mandel_stimulus.txt
# cmd <none|zoom_in|zoom_out|pan_left|pan_right|pan_up|pan_down> starts a step
# pix <x> <y> <expected rgb332 hex>; match_first compares the whole frame with step 0
cmd none
pix 0 0 6a
pix 15 0 25
pix 0 5 6a
pix 14 5 65
pix 10 5 00
pix 5 5 00
pix 8 4 00
pix 15 11 25
pix 0 11 6a
cmd zoom_in
pix 0 0 6a
pix 15 0 65
pix 15 11 00
pix 0 11 6a
cmd zoom_out
match_first
pix 14 5 65
pix 15 11 25
cmd pan_left
pix 0 0 6a
pix 10 5 00
pix 15 11 25
